/* mem_consts.svh */
// memory system constants for cache geometry, bank count and bank timing
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// cache geometry
`define CACHE_LINES 256
`define LINE_WORDS  4

// address field widths
`define TAG_W       5
`define INDEX_W     8
`define SEL_W       2
`define ROW_W       13

// banked main memory
`define NUM_BANKS   4
`define BANK_DEPTH  8192

// cycles from acceptance to read return
`define MEM_LATENCY 4

`endif

/* mem_pkg.sv */
// memory-side types for bank selection, bank rows and bank operations
`include "mem_consts.svh"

package mem_pkg;

   // word within a line, which is also the bank number
   typedef logic [`SEL_W-1:0] bank_sel_t;

   // row inside one bank, address bits 15 to 3
   typedef logic [`ROW_W-1:0] bank_row_t;

   typedef enum logic [1:0] {
      OP_IDLE,
      OP_READ,
      OP_WRITE
   } bank_op_t;

endpackage

/* cache_pkg.sv */
// cache-side types for the address views, line state and controller state
`include "mem_consts.svh"

package cache_pkg;

   // tag, index, word select, byte bit
   typedef struct packed {
      logic [`TAG_W-1:0]   tag;
      logic [`INDEX_W-1:0] index;
      mem_pkg::bank_sel_t  word;
      logic                byte_bit;
   } cache_view_t;

   // row, bank, byte bit
   typedef struct packed {
      mem_pkg::bank_row_t row;
      mem_pkg::bank_sel_t bank;
      logic               byte_bit;
   } mem_view_t;

   // one 16-bit address, seen by the cache or by the banks
   typedef union packed {
      cache_view_t c;
      mem_view_t   m;
   } addr_u;

   typedef struct packed {
      logic              valid;
      logic              dirty;
      logic [`TAG_W-1:0] tag;
   } line_state_t;

   typedef enum logic [2:0] {
      S_IDLE,
      S_COMPARE,
      S_WRITEBACK,
      S_FILL,
      S_FINISH
   } ctrl_state_t;

endpackage

/* bank_if.sv */
// one memory bank connection with request, write data, read return and busy
`timescale 1ns/100ps

interface bank_if
   import mem_pkg::*;
();

   // request side
   bank_op_t    op;
   bank_row_t   row;
   logic [15:0] wdata;

   // bank status and read return
   logic        busy;
   logic        rvalid;
   logic [15:0] rdata;

   modport dispatch (
      output op,
      output row,
      output wdata,
      input  busy
   );

   modport bank (
      input  op,
      input  row,
      input  wdata,
      output busy,
      output rvalid,
      output rdata
   );

   modport monitor (
      input rvalid,
      input rdata
   );

endinterface

/* cache_array.sv */
// direct-mapped cache storage with tag, valid, dirty and data plus tag compare
`timescale 1ns/100ps
`include "mem_consts.svh"

module cache_array
   import cache_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        c_enable,
   input  logic        c_write,
   input  logic        set_valid,
   input  logic        set_dirty,
   input  addr_u       c_addr,
   input  logic [15:0] c_wdata,
   output logic        tag_hit,
   output line_state_t line,
   output logic [15:0] rdata
);

   localparam int WORD_AW = `INDEX_W + `SEL_W;

   logic [`CACHE_LINES-1:0] valid_q;
   logic [`CACHE_LINES-1:0] dirty_q;
   logic [`TAG_W-1:0]       tag_mem [`CACHE_LINES];
   logic [15:0]             data_mem [`CACHE_LINES*`LINE_WORDS];

   logic [WORD_AW-1:0] word_addr;
   logic               wr_en;

   assign word_addr = {c_addr.c.index, c_addr.c.word};
   assign wr_en     = c_enable && c_write;

   // valid and dirty bits per line
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_en) begin
         valid_q[c_addr.c.index] <= set_valid;
         dirty_q[c_addr.c.index] <= set_dirty;
      end
   end

   // tag follows every write so a fill retags the line
   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_mem[c_addr.c.index] <= c_addr.c.tag;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_mem[word_addr] <= c_wdata;
      end
   end

   // combinational lookup of the addressed line
   always_comb begin
      line.valid = valid_q[c_addr.c.index];
      line.dirty = dirty_q[c_addr.c.index];
      line.tag   = tag_mem[c_addr.c.index];
   end

   assign rdata   = data_mem[word_addr];
   assign tag_hit = line.valid && (line.tag == c_addr.c.tag);

endmodule

/* cache_controller.sv */
// cache FSM that handles hits, dirty write-back and line fill from the banks
`timescale 1ns/100ps
`include "mem_consts.svh"

module cache_controller
   import cache_pkg::*;
   import mem_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] Addr,
   input  logic [15:0] DataIn,
   input  logic        Rd,
   input  logic        Wr,
   // cache array side
   output logic        c_enable,
   output logic        c_write,
   output addr_u       c_addr,
   output logic [15:0] c_wdata,
   output logic        set_valid,
   output logic        set_dirty,
   input  logic        tag_hit,
   input  line_state_t line,
   input  logic [15:0] rdata,
   // memory side
   output bank_op_t    mem_op,
   output addr_u       mem_addr,
   output logic [15:0] mem_wdata,
   input  logic        mem_stall,
   input  logic        fill_valid,
   input  bank_sel_t   fill_sel,
   input  logic [15:0] fill_data,
   // processor side
   output logic [15:0] DataOut,
   output logic        Done,
   output logic        Stall,
   output logic        CacheHit,
   output logic        err
);

   localparam bank_sel_t LAST_WORD = bank_sel_t'(`LINE_WORDS - 1);

   ctrl_state_t state;
   addr_u       req_addr;
   logic [15:0] req_data;
   logic        req_wr;
   logic        req_err;
   bank_sel_t   wb_cnt;
   bank_sel_t   rx_cnt;
   logic [2:0]  rd_cnt;
   logic        rd_issue;

   assign rd_issue = (rd_cnt < `LINE_WORDS);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= S_IDLE;
         req_err <= 1'b0;
         wb_cnt  <= '0;
         rx_cnt  <= '0;
         rd_cnt  <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (Rd || Wr) begin
                  state   <= S_COMPARE;
                  req_err <= Addr[0] || (Rd && Wr);
               end
            end
            S_COMPARE: begin
               if (req_err || tag_hit) begin
                  state <= S_IDLE;
               end else if (line.valid && line.dirty) begin
                  state <= S_WRITEBACK;
               end else begin
                  state <= S_FILL;
               end
            end
            S_WRITEBACK: begin
               // one victim word per cycle, bank 0 first
               if (!mem_stall) begin
                  wb_cnt <= wb_cnt + 1'b1;
                  if (wb_cnt == LAST_WORD) begin
                     state <= S_FILL;
                  end
               end
            end
            S_FILL: begin
               if (rd_issue && !mem_stall) begin
                  rd_cnt <= rd_cnt + 3'd1;
               end
               if (fill_valid) begin
                  rx_cnt <= rx_cnt + 1'b1;
                  if (rx_cnt == LAST_WORD) begin
                     state  <= S_FINISH;
                     rd_cnt <= '0;
                  end
               end
            end
            S_FINISH: begin
               state <= S_IDLE;
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // request held for the whole access
   always_ff @(posedge clk) begin
      if (state == S_IDLE && (Rd || Wr)) begin
         req_addr <= Addr;
         req_data <= DataIn;
         req_wr   <= Wr;
      end
   end

   always_comb begin
      c_addr    = req_addr;
      c_write   = 1'b0;
      c_wdata   = req_data;
      set_valid = 1'b1;
      set_dirty = 1'b1;
      mem_op    = OP_IDLE;
      mem_addr  = req_addr;
      mem_wdata = rdata;
      case (state)
         S_COMPARE: begin
            c_write = req_wr && !req_err && tag_hit;
         end
         S_WRITEBACK: begin
            // victim address uses the stored tag
            c_addr.c.word   = wb_cnt;
            mem_op          = OP_WRITE;
            mem_addr.c.tag  = line.tag;
            mem_addr.c.word = wb_cnt;
         end
         S_FILL: begin
            if (rd_issue) begin
               mem_op          = OP_READ;
               mem_addr.c.word = rd_cnt[1:0];
            end
            c_addr.c.word = fill_sel;
            c_write       = fill_valid;
            c_wdata       = fill_data;
            set_dirty     = 1'b0;
         end
         S_FINISH: begin
            c_write = req_wr;
         end
         default: begin
         end
      endcase
   end

   assign c_enable = (state != S_IDLE);

   assign err      = (state == S_COMPARE) && req_err;
   assign CacheHit = (state == S_COMPARE) && !req_err && tag_hit;
   assign Done     = err || CacheHit || (state == S_FINISH);
   assign Stall    = (state != S_IDLE) && !Done;
   assign DataOut  = rdata;

endmodule

/* bank_dispatch.sv */
// routes one word request to the bank picked by the address and flags a busy bank
`timescale 1ns/100ps
`include "mem_consts.svh"

module bank_dispatch
   import cache_pkg::*;
   import mem_pkg::*;
(
   input  bank_op_t       mem_op,
   input  addr_u          mem_addr,
   input  logic [15:0]    mem_wdata,
   output logic           mem_stall,
   bank_if.dispatch       banks [`NUM_BANKS]
);

   logic [`NUM_BANKS-1:0] busy_vec;

   for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
      // only the selected bank sees a live op
      assign banks[g].op    = (mem_addr.m.bank == bank_sel_t'(g)) ? mem_op : OP_IDLE;
      assign banks[g].row   = mem_addr.m.row;
      assign banks[g].wdata = mem_wdata;
      assign busy_vec[g]    = banks[g].busy;
   end

   assign mem_stall = (mem_op != OP_IDLE) && busy_vec[mem_addr.m.bank];

endmodule

/* mem_bank.sv */
// single memory bank with fixed access latency and one access in flight
`timescale 1ns/100ps
`include "mem_consts.svh"

module mem_bank
   import mem_pkg::*;
(
   input logic   clk,
   input logic   rst_n,
   bank_if.bank  bus
);

   localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

   logic [15:0]      mem [`BANK_DEPTH];
   logic [CNT_W-1:0] cnt;
   logic             rd_pend;
   logic [15:0]      rd_q;
   logic             accept;

   // simulation start state
   initial begin
      for (int i = 0; i < `BANK_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   assign accept = (bus.op != OP_IDLE) && !bus.busy;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt     <= '0;
         rd_pend <= 1'b0;
      end else if (accept) begin
         cnt     <= CNT_W'(`MEM_LATENCY);
         rd_pend <= (bus.op == OP_READ);
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   // storage access happens at acceptance
   always_ff @(posedge clk) begin
      if (accept) begin
         if (bus.op == OP_WRITE) begin
            mem[bus.row] <= bus.wdata;
         end else begin
            rd_q <= mem[bus.row];
         end
      end
   end

   assign bus.busy   = (cnt != '0);
   assign bus.rvalid = rd_pend && (cnt == CNT_W'(1));
   assign bus.rdata  = rd_q;

endmodule

/* bank_merge.sv */
// merges bank read returns into one fill word tagged with its word select
`timescale 1ns/100ps
`include "mem_consts.svh"

module bank_merge
   import mem_pkg::*;
(
   bank_if.monitor     banks [`NUM_BANKS],
   output logic        fill_valid,
   output bank_sel_t   fill_sel,
   output logic [15:0] fill_data
);

   logic [`NUM_BANKS-1:0] rv;
   logic [15:0]           rd [`NUM_BANKS];

   for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_tap
      assign rv[g] = banks[g].rvalid;
      assign rd[g] = banks[g].rdata;
   end

   // at most one bank returns in any cycle
   always_comb begin
      fill_valid = |rv;
      fill_sel   = '0;
      fill_data  = '0;
      for (int b = 0; b < `NUM_BANKS; b++) begin
         if (rv[b]) begin
            fill_sel  = bank_sel_t'(b);
            fill_data = rd[b];
         end
      end
   end

endmodule

/* mem_system.sv */
// cache memory system top with controller, cache array and four-bank memory
`timescale 1ns/100ps
`include "mem_consts.svh"

module mem_system
   import cache_pkg::*;
   import mem_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] Addr,
   input  logic [15:0] DataIn,
   input  logic        Rd,
   input  logic        Wr,
   output logic [15:0] DataOut,
   output logic        Done,
   output logic        Stall,
   output logic        CacheHit,
   output logic        err
);

   // controller to cache array
   logic        c_enable;
   logic        c_write;
   logic        set_valid;
   logic        set_dirty;
   addr_u       c_addr;
   logic [15:0] c_wdata;
   logic        tag_hit;
   line_state_t line;
   logic [15:0] c_rdata;

   // controller to memory
   bank_op_t    mem_op;
   addr_u       mem_addr;
   logic [15:0] mem_wdata;
   logic        mem_stall;
   logic        fill_valid;
   bank_sel_t   fill_sel;
   logic [15:0] fill_data;

   bank_if bank_bus [`NUM_BANKS] ();

   cache_controller u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .Addr       (Addr),
      .DataIn     (DataIn),
      .Rd         (Rd),
      .Wr         (Wr),
      .c_enable   (c_enable),
      .c_write    (c_write),
      .c_addr     (c_addr),
      .c_wdata    (c_wdata),
      .set_valid  (set_valid),
      .set_dirty  (set_dirty),
      .tag_hit    (tag_hit),
      .line       (line),
      .rdata      (c_rdata),
      .mem_op     (mem_op),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_stall  (mem_stall),
      .fill_valid (fill_valid),
      .fill_sel   (fill_sel),
      .fill_data  (fill_data),
      .DataOut    (DataOut),
      .Done       (Done),
      .Stall      (Stall),
      .CacheHit   (CacheHit),
      .err        (err)
   );

   cache_array u_cache (
      .clk       (clk),
      .rst_n     (rst_n),
      .c_enable  (c_enable),
      .c_write   (c_write),
      .set_valid (set_valid),
      .set_dirty (set_dirty),
      .c_addr    (c_addr),
      .c_wdata   (c_wdata),
      .tag_hit   (tag_hit),
      .line      (line),
      .rdata     (c_rdata)
   );

   bank_dispatch u_dispatch (
      .mem_op    (mem_op),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_stall (mem_stall),
      .banks     (bank_bus)
   );

   bank_merge u_merge (
      .banks      (bank_bus),
      .fill_valid (fill_valid),
      .fill_sel   (fill_sel),
      .fill_data  (fill_data)
   );

   for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
      mem_bank u_bank (
         .clk   (clk),
         .rst_n (rst_n),
         .bus   (bank_bus[g])
      );
   end

endmodule

/* tb_mem_system.sv */
// self-checking testbench for the cache and four-bank memory system
`timescale 1ns/100ps

module tb_mem_system;

   localparam int WAIT_LIMIT = 200;
   localparam int RAND_OPS   = 300;

   logic        clk;
   logic        rst_n;
   logic [15:0] Addr;
   logic [15:0] DataIn;
   logic        Rd;
   logic        Wr;
   logic [15:0] DataOut;
   logic        Done;
   logic        Stall;
   logic        CacheHit;
   logic        err;

   // reference model of a flat word memory plus per-line state
   bit [15:0] ref_mem [32768];
   bit        ref_valid [256];
   bit        ref_dirty [256];
   bit [4:0]  ref_tag [256];

   // expectations for the request in flight
   string       cur_name;
   logic [15:0] exp_data;
   logic        exp_hit;
   logic        exp_err;
   logic        exp_rd;
   logic        pending;
   int          done_count;

   mem_system u_mem_system (
      .clk      (clk),
      .rst_n    (rst_n),
      .Addr     (Addr),
      .DataIn   (DataIn),
      .Rd       (Rd),
      .Wr       (Wr),
      .DataOut  (DataOut),
      .Done     (Done),
      .Stall    (Stall),
      .CacheHit (CacheHit),
      .err      (err)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic halt_with_failure();
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_problem(input string msg);
      $display("%s", msg);
      halt_with_failure();
   endtask

   task automatic check_data(
      input string       name,
      input logic [15:0] expected,
      input logic [15:0] actual
   );
      if (actual !== expected) begin
         $display("ERR %s: expected %h, actual %h", name, expected, actual);
         halt_with_failure();
      end
   endtask

   task automatic check_hit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERR %s: expected CacheHit %b, actual %b", name, expected, actual);
         halt_with_failure();
      end
   endtask

   task automatic check_err(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERR %s: expected err %b, actual %b", name, expected, actual);
         halt_with_failure();
      end
   endtask

   // Done and Stall levels
   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERR %s: expected %b, actual %b", name, expected, actual);
         halt_with_failure();
      end
   endtask

   // expected outcome of one request, and the model update it causes
   function automatic void model_access(
      input  logic [15:0] addr,
      input  logic [15:0] wdata,
      input  logic        rd,
      input  logic        wr,
      output logic [15:0] data_o,
      output logic        hit_o,
      output logic        err_o
   );
      logic [4:0] tag;
      logic [7:0] idx;
      tag    = addr[15:11];
      idx    = addr[10:3];
      err_o  = addr[0] || (rd && wr);
      hit_o  = 1'b0;
      data_o = ref_mem[addr[15:1]];
      if (!err_o) begin
         hit_o = ref_valid[idx] && (ref_tag[idx] == tag);
         // a miss allocates the line clean, a write then dirties it
         if (!hit_o) begin
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tag;
            ref_dirty[idx] = 1'b0;
         end
         if (wr) begin
            ref_mem[addr[15:1]] = wdata;
            ref_dirty[idx]      = 1'b1;
         end
      end
   endfunction

   // compare at the edge that closes each Done cycle
   always @(posedge clk) begin
      if (rst_n && Done === 1'b1) begin
         if (!pending) begin
            report_problem("Done was raised with no request outstanding");
         end
         check_err(cur_name, exp_err, err);
         check_hit(cur_name, exp_hit, CacheHit);
         if (exp_rd && !exp_err) begin
            check_data(cur_name, exp_data, DataOut);
         end
         pending = 1'b0;
         done_count++;
      end
   end

   // one request, held for a single cycle, then wait for Done
   task automatic access(
      input string       name,
      input logic [15:0] addr,
      input logic [15:0] wdata,
      input logic        rd,
      input logic        wr
   );
      int start_count;
      int cycles;
      @(negedge clk);
      model_access(addr, wdata, rd, wr, exp_data, exp_hit, exp_err);
      cur_name    = name;
      exp_rd      = rd;
      pending     = 1'b1;
      start_count = done_count;
      Addr        = addr;
      DataIn      = wdata;
      Rd          = rd;
      Wr          = wr;
      @(negedge clk);
      Rd     = 1'b0;
      Wr     = 1'b0;
      cycles = 0;
      while (done_count == start_count) begin
         // hits and illegal requests finish in the cycle after acceptance
         if (cycles == 0 && Done !== (exp_hit || exp_err)) begin
            report_problem($sformatf("%s: Done was not where a hit or a miss puts it", name));
         end
         if (Stall !== 1'b1 && Done !== 1'b1) begin
            report_problem($sformatf("%s: Stall went low before Done", name));
         end
         if (cycles >= WAIT_LIMIT) begin
            report_problem($sformatf("%s: Done never came", name));
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   initial begin
      logic [15:0] a;
      logic [15:0] d;
      logic        is_wr;
      rst_n      = 1'b0;
      Addr       = '0;
      DataIn     = '0;
      Rd         = 1'b0;
      Wr         = 1'b0;
      cur_name   = "none";
      exp_data   = '0;
      exp_hit    = 1'b0;
      exp_err    = 1'b0;
      exp_rd     = 1'b0;
      pending    = 1'b0;
      done_count = 0;
      void'($urandom(32'hed75_1555));

      repeat (16) @(negedge clk);
      rst_n = 1'b1;

      // outputs quiet after reset
      check_flag("reset Done", 1'b0, Done);
      check_flag("reset Stall", 1'b0, Stall);
      check_hit("reset CacheHit", 1'b0, CacheHit);
      check_err("reset err", 1'b0, err);

      // cold write allocates, read back hits
      access("cold write", 16'h0200, 16'h5a5a, 1'b0, 1'b1);
      access("read after write", 16'h0200, 16'h0000, 1'b1, 1'b0);

      // same index, different tag, dirty victim on each swap
      access("conflict write A", 16'h0010, 16'haaaa, 1'b0, 1'b1);
      access("conflict write B", 16'h0810, 16'hbbbb, 1'b0, 1'b1);
      access("conflict read A", 16'h0010, 16'h0000, 1'b1, 1'b0);
      access("conflict read B", 16'h0810, 16'h0000, 1'b1, 1'b0);

      // fill a line in the banks through an eviction
      access("line word 0 write", 16'h1028, 16'h1111, 1'b0, 1'b1);
      access("line word 1 write", 16'h102a, 16'h2222, 1'b0, 1'b1);
      access("line word 2 write", 16'h102c, 16'h3333, 1'b0, 1'b1);
      access("line word 3 write", 16'h102e, 16'h4444, 1'b0, 1'b1);
      access("line evict", 16'h1828, 16'h9999, 1'b0, 1'b1);
      // one fill, then three hits from it
      access("line read word 2", 16'h102c, 16'h0000, 1'b1, 1'b0);
      access("line read word 0", 16'h1028, 16'h0000, 1'b1, 1'b0);
      access("line read word 1", 16'h102a, 16'h0000, 1'b1, 1'b0);
      access("line read word 3", 16'h102e, 16'h0000, 1'b1, 1'b0);

      // illegal requests leave cache and memory alone
      access("err setup write", 16'h0040, 16'h1234, 1'b0, 1'b1);
      access("err odd write", 16'h0041, 16'hdead, 1'b0, 1'b1);
      access("err rd and wr", 16'h0040, 16'hbeef, 1'b1, 1'b1);
      access("err check hit", 16'h0040, 16'h0000, 1'b1, 1'b0);
      access("err odd cold", 16'h3001, 16'h7777, 1'b0, 1'b1);
      access("err check cold", 16'h3000, 16'h0000, 1'b1, 1'b0);

      // random aligned traffic over four tags and four indices
      for (int i = 0; i < RAND_OPS; i++) begin
         a        = 16'h0000;
         a[15:11] = 5'($urandom_range(3, 0));
         a[10:3]  = 8'(16 + $urandom_range(3, 0));
         a[2:1]   = 2'($urandom_range(3, 0));
         d        = 16'($urandom);
         is_wr    = 1'($urandom_range(1, 0));
         access($sformatf("random %0d", i), a, d, !is_wr, is_wr);
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

/* sim.f */
+incdir+.
mem_pkg.sv
cache_pkg.sv
bank_if.sv
cache_array.sv
cache_controller.sv
bank_dispatch.sv
mem_bank.sv
bank_merge.sv
mem_system.sv
tb_mem_system.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_mem_system -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_system 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Test completed successfully" <<< "$sim_out"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1
